//--- Makefile
VERILATOR  ?= verilator
TOP        := colmix_tb
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# The log decides the verdict, not the simulator exit code
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- colmix/layer_prio.sv
// Layer priority: picks the frontmost opaque layer pixel and forms its palette address
`timescale 1ns/100ps

module layer_prio (
    input  colmix_pkg::layer_pxl_t layers,
    output colmix_pkg::pal_addr_t  pal_addr
);
    import colmix_pkg::*;

    logic char_op;                      // Opaque flags per layer
    logic obj_op;
    logic scr1_op;
    logic scr2_op;

    pal_addr_t char_addr;               // Candidate addresses
    pal_addr_t obj_addr;
    pal_addr_t scr1_addr;
    pal_addr_t scr2_addr;

    // Low nibble carries transparency for every layer
    assign char_op = is_opaque(layers.char_pxl[3:0]);
    assign obj_op  = is_opaque(layers.obj_pxl[3:0]);
    assign scr1_op = is_opaque(layers.scr1_pxl[3:0]);
    assign scr2_op = is_opaque(layers.scr2_pxl[3:0]);

    // Text uses only the first 64 entries
    assign char_addr = {5'd0, layers.char_pxl[5:0]};
    // Sprites live in the upper half, priority bits dropped
    assign obj_addr  = {1'b1, layers.obj_pxl[9:0]};
    // Scroll layers share the lower half
    assign scr1_addr = {1'b0, layers.scr1_pxl[9:0]};
    assign scr2_addr = {1'b0, layers.scr2_pxl[9:0]};

    // Fixed order: char, object, scroll 1, scroll 2
    always_comb begin
        if (char_op) begin
            pal_addr = char_addr;
        end else if (obj_op) begin
            pal_addr = obj_addr;
        end else if (scr1_op) begin
            pal_addr = scr1_addr;
        end else if (scr2_op) begin
            pal_addr = scr2_addr;
        end else begin
            pal_addr = '0;              // Backdrop colour
        end
    end

endmodule

//--- colmix/palette_ram.sv
// Palette RAM: dual-port 2048x16 with CPU byte-lane access and a registered video read
`timescale 1ns/100ps

module palette_ram (
    input                         clk,
    input                         pal_cs,
    input  colmix_pkg::cpu_addr_t cpu_addr,
    input  colmix_pkg::pal_word_t cpu_dout,
    input  [1:0]                  dsn,
    output colmix_pkg::pal_word_t cpu_din,
    input  colmix_pkg::pal_addr_t pal_addr,
    output colmix_pkg::pal_word_t pal_data
);
    import colmix_pkg::*;

    logic [1:0] we;                     // Lane write enables

    // Strobes are active low, chip select high
    assign we = ~dsn & {2{pal_cs}};

    // One byte-wide RAM per data lane, lane 1 is the high byte
    for (genvar i = 0; i < 2; i++) begin : g_lane
        logic [7:0] mem [PAL_WORDS];    // Block RAM, no reset
        logic [7:0] cpu_q;              // CPU read data
        logic [7:0] vid_q;              // Video read data

        // CPU side, old data returned on a write to the same word
        always_ff @(posedge clk) begin
            if (we[i]) begin
                mem[cpu_addr] <= cpu_dout[i*8 +: 8];
            end
            cpu_q <= mem[cpu_addr];
        end

        // Video side is read only
        always_ff @(posedge clk) begin
            vid_q <= mem[pal_addr];
        end
    end

    // Rejoin the lanes
    assign cpu_din  = {g_lane[1].cpu_q, g_lane[0].cpu_q};
    assign pal_data = {g_lane[1].vid_q, g_lane[0].vid_q};

endmodule

//--- colmix/video_out.sv
// Video output stage: blanking-aligned colour delay, channel unpack and blank to black
`timescale 1ns/100ps

module video_out #(
    parameter int DLY = colmix_pkg::DLY_DEF    // Depth in pixel enables, 1 or more
) (
    input                         clk,
    input                         rst_n,
    input                         pxl_cen,
    input  colmix_pkg::vsync_t    vsync,
    input  colmix_pkg::pal_word_t pal_data,
    output colmix_pkg::vsync_t    vsync_dly,
    output colmix_pkg::rgb_out_t  rgb
);
    import colmix_pkg::*;

    // One stage of the delay line, colour kept with its own blanking
    typedef struct packed {
        vsync_t sync;
        rgb15_t color;
    } dly_word_t;

    dly_word_t pipe [DLY];              // Stage 0 takes the new pixel
    dly_word_t tail;                    // Oldest stage
    dly_word_t head;                    // Incoming pixel
    logic      blank;

    // Bit 15 of the palette word is unused
    assign head.sync  = vsync;
    assign head.color = pal_data[14:0];

    // Shift once per pixel, cleared to blanking at reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DLY; i++) begin
                pipe[i] <= '0;          // Sync low reads as blank
            end
        end else if (pxl_cen) begin
            pipe[0] <= head;
            for (int i = 1; i < DLY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    assign tail      = pipe[DLY-1];
    assign vsync_dly = tail.sync;

    // Either blank active forces black
    assign blank = ~tail.sync.lhbl | ~tail.sync.lvbl;

    // Four main bits then the shared low bit per channel
    always_comb begin
        rgb.red   = {tail.color[3:0],  tail.color[12]};
        rgb.green = {tail.color[7:4],  tail.color[13]};
        rgb.blue  = {tail.color[11:8], tail.color[14]};
        if (blank) begin
            rgb = '0;
        end
    end

endmodule

//--- common/colmix_pkg.sv
// Colour mixer shared types: layer pixels, palette words, colours and sync levels
package colmix_pkg;

    // Default output delay in pixel enables
    localparam int unsigned DLY_DEF = 12;

    // Palette size in words, one per address
    localparam int unsigned PAL_AW    = 11;
    localparam int unsigned PAL_WORDS = 1 << PAL_AW;

    // Layer pixel formats
    typedef logic [6:0]  char_pxl_t;    // Colour nibble, index bits and bank
    typedef logic [10:0] scr_pxl_t;     // 10-bit index plus priority bit
    typedef logic [11:0] obj_pxl_t;     // 10-bit index, 2-bit priority on top

    // Palette and CPU side
    typedef logic [PAL_AW-1:0] pal_addr_t;  // MSB selects object half
    typedef logic [PAL_AW-1:0] cpu_addr_t;  // Word address, byte bits 11..1
    typedef logic [15:0]       pal_word_t;

    // Colour formats
    typedef logic [14:0] rgb15_t;       // 4-bit R,G,B fields then three LSBs
    typedef logic [4:0]  color5_t;

    // All four layers for one pixel
    typedef struct packed {
        char_pxl_t char_pxl;            // Text layer, front
        scr_pxl_t  scr1_pxl;
        scr_pxl_t  scr2_pxl;            // Back scroll
        obj_pxl_t  obj_pxl;             // Sprites
    } layer_pxl_t;

    // Blanking levels, low means blank
    typedef struct packed {
        logic lhbl;                     // Horizontal
        logic lvbl;                     // Vertical
    } vsync_t;

    // Final colour to the DAC
    typedef struct packed {
        color5_t red;
        color5_t green;
        color5_t blue;
    } rgb_out_t;

    // Opaque unless the colour nibble is zero
    function automatic logic is_opaque(input logic [3:0] nibble);
        return nibble != 4'd0;
    endfunction

endpackage

//--- project.f
common/colmix_pkg.sv
colmix/layer_prio.sv
colmix/palette_ram.sv
colmix/video_out.sv
source/colmix_top.sv
test/clock_gen.sv
test/colmix_checker.sv
test/colmix_tb.sv

//--- source/colmix_top.sv
// Colour mixer top: layer priority into palette RAM, then delayed output with blanking
`timescale 1ns/100ps

module colmix_top #(
    parameter int DLY = colmix_pkg::DLY_DEF    // Output latency in pixel enables
) (
    input                          clk,
    input                          rst_n,
    input                          pxl_cen,     // One-cycle pixel strobe
    input  colmix_pkg::vsync_t     vsync,
    input  colmix_pkg::layer_pxl_t layers,
    // CPU palette port
    input                          pal_cs,
    input  colmix_pkg::cpu_addr_t  cpu_addr,
    input  colmix_pkg::pal_word_t  cpu_dout,
    input  [1:0]                   dsn,         // Byte strobes, active low
    output colmix_pkg::pal_word_t  cpu_din,
    // Video out
    output colmix_pkg::rgb_out_t   rgb,
    output colmix_pkg::vsync_t     vsync_dly
);
    import colmix_pkg::*;

    pal_addr_t pal_addr;                // Winning layer's entry
    pal_word_t pal_data;                // Registered palette read

    layer_prio u_prio (
        .layers   (layers),
        .pal_addr (pal_addr)
    );

    palette_ram u_pal (
        .clk      (clk),
        .pal_cs   (pal_cs),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .dsn      (dsn),
        .cpu_din  (cpu_din),
        .pal_addr (pal_addr),
        .pal_data (pal_data)
    );

    // Delay matches the blanking of the board's video timing
    video_out #(
        .DLY (DLY)
    ) u_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .vsync     (vsync),
        .pal_data  (pal_data),
        .vsync_dly (vsync_dly),
        .rgb       (rgb)
    );

endmodule

//--- test/clock_gen.sv
// Testbench clock and reset source: free-running clock, synchronous reset held for a fixed count
`timescale 1ns/100ps

module clock_gen #(
    parameter int PERIOD     = 20,      // ns
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;                   // Release away from the sampling edge
    end

endmodule

//--- test/colmix_checker.sv
// Output checker: blanking, reset and pixel-rate hold rules on the colour mixer outputs
`timescale 1ns/100ps

module colmix_checker (
    input                        clk,
    input                        rst_n,
    input                        pxl_cen,
    input  colmix_pkg::vsync_t   vsync_dly,
    input  colmix_pkg::rgb_out_t rgb
);

    int fail_cnt = 0;                   // Polled by the testbench

    // Either blank low means black
    a_blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (!vsync_dly.lhbl || !vsync_dly.lvbl) |-> (rgb == '0))
        else begin
            $error("rgb not black while blanking");
            fail_cnt++;
        end

    // Delay line cleared to blanking
    a_reset_blank: assert property (@(posedge clk)
        !rst_n |=> (vsync_dly == '0))
        else begin
            $error("vsync_dly not blanking after a reset clock");
            fail_cnt++;
        end

    // Output only moves on a pixel enable
    a_rgb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && !$past(pxl_cen)) |-> $stable(rgb))
        else begin
            $error("rgb changed between pixel enables");
            fail_cnt++;
        end

endmodule

//--- test/colmix_tb.sv
// Colour mixer testbench: CPU palette access, layer priority, channel unpack and blanking delay
`timescale 1ns/100ps

module colmix_tb;
    import colmix_pkg::*;

    localparam int DLY          = 12;
    localparam int CLK_PERIOD   = 20;
    localparam int N_BYTE       = 200;  // Random single-lane writes
    localparam int N_PRIO       = 300;
    localparam int N_UNPACK     = 16;   // One per palette bit
    localparam int N_BLANK      = 200;
    localparam int TOTAL_PIXELS = N_PRIO + N_UNPACK + N_BLANK + DLY;
    localparam int CPU_CLKS     = int'(PAL_WORDS) * 4 + N_BYTE * 4 + N_UNPACK * 2;
    localparam int WDOG_CYCLES  = TOTAL_PIXELS * 4 + CPU_CLKS + 500;

    typedef struct packed {
        vsync_t   sync;
        rgb_out_t rgb;
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       pxl_cen;
    vsync_t     vsync;
    layer_pxl_t layers;
    logic       pal_cs;
    cpu_addr_t  cpu_addr;
    pal_word_t  cpu_dout;
    logic [1:0] dsn;
    pal_word_t  cpu_din;
    rgb_out_t   rgb;
    vsync_t     vsync_dly;

    pal_word_t   pal_model [PAL_WORDS];  // Mirror of every CPU write
    expect_t     exp_q [$];              // One entry per pixel enable
    logic [31:0] rng_state = 32'he5a57bb4;
    int          pixel_cnt = 0;
    int          check_cnt = 0;

    clock_gen #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (8)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    colmix_top #(
        .DLY (DLY)
    ) u_colmix_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .vsync     (vsync),
        .layers    (layers),
        .pal_cs    (pal_cs),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .dsn       (dsn),
        .cpu_din   (cpu_din),
        .rgb       (rgb),
        .vsync_dly (vsync_dly)
    );

    bind colmix_top colmix_checker u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .vsync_dly (vsync_dly),
        .rgb       (rgb)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Expected colour: back to front, so the frontmost opaque layer wins
    function automatic rgb_out_t ref_rgb(input layer_pxl_t lp, input vsync_t vs);
        pal_addr_t a;
        pal_word_t w;
        rgb_out_t  c;
        a = '0;                                                 // Backdrop
        if (lp.scr2_pxl[3:0] != 4'd0) a = {1'b0, lp.scr2_pxl[9:0]};
        if (lp.scr1_pxl[3:0] != 4'd0) a = {1'b0, lp.scr1_pxl[9:0]};
        if (lp.obj_pxl[3:0] != 4'd0)  a = {1'b1, lp.obj_pxl[9:0]};  // Object half
        if (lp.char_pxl[3:0] != 4'd0) a = {5'd0, lp.char_pxl[5:0]};
        w = pal_model[a];
        c.red   = {w[3:0], w[12]};
        c.green = {w[7:4], w[13]};
        c.blue  = {w[11:8], w[14]};
        if (!(vs.lhbl && vs.lvbl)) begin
            c = '0;
        end
        return c;
    endfunction

    // Random pixels, each layer cleared about half the time
    function automatic layer_pxl_t rand_layers();
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic [31:0] r_tr;
        layer_pxl_t  lp;
        r_hi = next_rand();
        r_lo = next_rand();
        r_tr = next_rand();
        lp = {r_hi, r_lo[31:23]};       // Upper LCG bits only
        if (r_tr[31]) lp.char_pxl[3:0] = 4'd0;
        if (r_tr[30]) lp.obj_pxl[3:0]  = 4'd0;
        if (r_tr[29]) lp.scr1_pxl[3:0] = 4'd0;
        if (r_tr[28]) lp.scr2_pxl[3:0] = 4'd0;
        return lp;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_rgb(input string name, input rgb_out_t got, input rgb_out_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_sync(input string name, input vsync_t got, input vsync_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input pal_word_t got, input pal_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // One CPU write clock, optionally checking the read-first data
    task automatic cpu_write(input cpu_addr_t addr, input pal_word_t data,
                             input logic [1:0] strobe, input logic check_old);
        pal_word_t old;
        old = pal_model[addr];
        @(negedge clk);
        pxl_cen  = 1'b0;
        pal_cs   = 1'b1;
        cpu_addr = addr;
        cpu_dout = data;
        dsn      = strobe;
        if (!strobe[0]) begin
            pal_model[addr][7:0] = data[7:0];
        end
        if (!strobe[1]) begin
            pal_model[addr][15:8] = data[15:8];     // Upper lane
        end
        @(negedge clk);
        pal_cs = 1'b0;
        dsn    = 2'b11;
        if (check_old) begin
            check_word("cpu_din", cpu_din, old);
        end
    endtask

    task automatic cpu_read_check(input cpu_addr_t addr);
        @(negedge clk);
        pxl_cen  = 1'b0;
        pal_cs   = 1'b0;
        cpu_addr = addr;
        @(negedge clk);
        check_word("cpu_din", cpu_din, pal_model[addr]);
    endtask

    // Two clocks per pixel, enable in the second
    task automatic drive_pixel(input layer_pxl_t lp, input vsync_t vs);
        expect_t e;
        @(negedge clk);
        pxl_cen = 1'b0;
        layers  = lp;
        vsync   = vs;
        @(negedge clk);
        e.sync = vs;
        e.rgb  = ref_rgb(lp, vs);
        exp_q.push_back(e);
        pixel_cnt++;
        pxl_cen = 1'b1;
    endtask

    // Compare after each enable, reset state until DLY pixels are in
    initial begin
        expect_t e;
        forever begin
            @(posedge clk);
            if (rst_n && pxl_cen) begin
                @(negedge clk);
                if (exp_q.size() >= DLY) begin
                    e = exp_q.pop_front();
                end else begin
                    e = '0;
                end
                check_sync("vsync_dly", vsync_dly, e.sync);
                check_rgb("rgb", rgb, e.rgb);
                if (u_colmix_top.u_chk.fail_cnt != 0) begin
                    abort_run("An output assertion failed");
                end
                check_cnt++;
            end
        end
    end

    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        abort_run("Timeout: the run did not finish within the expected number of clocks");
    end

    initial begin
        logic [31:0] r;
        cpu_addr_t   a;
        layer_pxl_t  lp;
        pxl_cen  = 1'b0;
        vsync    = '0;
        layers   = '0;
        pal_cs   = 1'b0;
        cpu_addr = '0;
        cpu_dout = '0;
        dsn      = 2'b11;
        wait (rst_n == 1'b1);
        @(negedge clk);
        check_sync("vsync_dly", vsync_dly, '0);   // Cleared delay line
        check_rgb("rgb", rgb, '0);

        // Fill every word, then read all back
        for (int i = 0; i < int'(PAL_WORDS); i++) begin
            r = next_rand();
            cpu_write(cpu_addr_t'(i), r[31:16], 2'b00, 1'b0);
        end
        for (int i = 0; i < int'(PAL_WORDS); i++) begin
            cpu_read_check(cpu_addr_t'(i));
        end

        // Single lane merges
        for (int i = 0; i < N_BYTE; i++) begin
            r = next_rand();
            a = r[31:21];
            cpu_write(a, r[26:11], r[20] ? 2'b10 : 2'b01, 1'b1);
            cpu_read_check(a);
        end

        for (int i = 0; i < N_PRIO; i++) begin
            drive_pixel(rand_layers(), 2'b11);
        end

        // Single palette bits through the backdrop entry
        for (int b = 0; b < N_UNPACK; b++) begin
            cpu_write('0, 16'h0001 << b, 2'b00, 1'b1);
            lp = rand_layers();
            lp.char_pxl[3:0] = 4'd0;
            lp.obj_pxl[3:0]  = 4'd0;
            lp.scr1_pxl[3:0] = 4'd0;
            lp.scr2_pxl[3:0] = 4'd0;
            drive_pixel(lp, 2'b11);
        end

        for (int i = 0; i < N_BLANK; i++) begin
            r = next_rand();
            drive_pixel(rand_layers(), vsync_t'(r[31:30]));
        end

        // Push the last pixels out
        for (int i = 0; i < DLY; i++) begin
            drive_pixel(rand_layers(), 2'b11);
        end
        @(negedge clk);
        pxl_cen = 1'b0;
        wait (check_cnt == pixel_cnt);

        if (u_colmix_top.u_chk.fail_cnt == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("Output assertions reported failures");
        end
    end

endmodule
